//--- design/rv_isa_pkg.sv
package rv_isa_pkg;

    // major opcodes, bits [6:0] of every instruction
    typedef enum logic [6:0] {
        op_alu    = 7'b0110011, // register-register
        op_alui   = 7'b0010011, // register-immediate
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_branch = 7'b1100011,
        op_jal    = 7'b1101111,
        op_jalr   = 7'b1100111,
        op_lui    = 7'b0110111,
        op_auipc  = 7'b0010111,
        op_system = 7'b1110011  // ecall / ebreak
    } opcode_t;

    // alu funct3 codes
    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_sll     = 3'b001;
    localparam logic [2:0] f3_slt     = 3'b010;
    localparam logic [2:0] f3_sltu    = 3'b011;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_srl_sra = 3'b101;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;

    // branch funct3 codes, 3'b010 and 3'b011 are unused
    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;
    localparam logic [2:0] f3_blt  = 3'b100;
    localparam logic [2:0] f3_bge  = 3'b101;
    localparam logic [2:0] f3_bltu = 3'b110;
    localparam logic [2:0] f3_bgeu = 3'b111;

    // selects sub and sra/srai
    localparam logic [6:0] funct7_alt = 7'b0100000;

    // low bit of each field above the opcode
    localparam int rd_lsb     = 7;
    localparam int funct3_lsb = 12;
    localparam int rs1_lsb    = 15;
    localparam int rs2_lsb    = 20;
    localparam int funct7_lsb = 25;

endpackage

//--- design/core_pkg.sv
package core_pkg;

    localparam int xlen = 32; // data and address width

    typedef logic [xlen-1:0] word_t;
    typedef logic [4:0]      reg_idx_t; // x0..x31

    // controller steps, codes are visible on dbg_state
    typedef enum logic [3:0] {
        init      = 4'd0,
        fetch     = 4'd1,
        decode    = 4'd2,
        execute   = 4'd3,
        memory    = 4'd4,
        writeback = 4'd5,
        halt      = 4'd6, // ecall / ebreak seen
        error     = 4'd7  // unknown opcode
    } core_state_t;

    localparam word_t reset_pc = '0; // first fetch address

endpackage

//--- design/regfile_if.sv
interface regfile_if;

    core_pkg::reg_idx_t r_sel_1;  // rs1 index
    core_pkg::reg_idx_t r_sel_2;  // rs2 index
    core_pkg::word_t    r_data_1; // combinational read data
    core_pkg::word_t    r_data_2;
    logic               w_en;     // write on rising edge
    core_pkg::reg_idx_t w_sel;
    core_pkg::word_t    w_data;

    // controller side
    modport ctrl (
        output r_sel_1, r_sel_2, w_en, w_sel, w_data,
        input  r_data_1, r_data_2
    );

    // register file side
    modport rf (
        input  r_sel_1, r_sel_2, w_en, w_sel, w_data,
        output r_data_1, r_data_2
    );

endinterface

//--- design/regfile.sv
module regfile (
    input  logic               clk,
    input  logic               rst_n,
    input  core_pkg::reg_idx_t dbg_sel,  // debug read index
    regfile_if.rf              bus,
    output core_pkg::word_t    dbg_data
);

    core_pkg::word_t regs [1:31]; // x0 has no storage

    // x0 always reads as zero
    function automatic core_pkg::word_t read_reg(core_pkg::reg_idx_t sel);
        core_pkg::word_t val;
        val = '0;
        if (sel != '0) val = regs[sel];
        return val;
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (bus.w_en && bus.w_sel != '0) begin // writes to x0 dropped
            regs[bus.w_sel] <= bus.w_data;
        end
    end

    // three independent asynchronous read ports
    always_comb begin
        bus.r_data_1 = read_reg(bus.r_sel_1);
        bus.r_data_2 = read_reg(bus.r_sel_2);
        dbg_data     = read_reg(dbg_sel);
    end

endmodule

//--- design/imm_decoder.sv
module imm_decoder (
    input  core_pkg::word_t instr,
    output core_pkg::word_t imm
);

    rv_isa_pkg::opcode_t opcode;

    assign opcode = rv_isa_pkg::opcode_t'(instr[6:0]);

    // instr[31] is the sign bit in every format
    always_comb begin
        case (opcode)
            rv_isa_pkg::op_alui, rv_isa_pkg::op_load, rv_isa_pkg::op_jalr: begin
                imm = {{20{instr[31]}}, instr[31:20]}; // I-type
            end
            rv_isa_pkg::op_store: begin
                imm = {{20{instr[31]}}, instr[31:25], instr[11:7]}; // S-type
            end
            rv_isa_pkg::op_branch: begin
                // B-type, offset in half words so bit 0 is zero
                imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                       instr[11:8], 1'b0};
            end
            rv_isa_pkg::op_lui, rv_isa_pkg::op_auipc: begin
                imm = {instr[31:12], 12'b0}; // U-type, upper 20 bits
            end
            rv_isa_pkg::op_jal: begin
                // J-type
                imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                       instr[30:21], 1'b0};
            end
            default: begin
                imm = '0; // R-type and unknown formats carry no immediate
            end
        endcase
    end

endmodule

//--- design/alu.sv
module alu (
    input  logic [2:0]      funct3,
    input  logic [6:0]      funct7,
    input  logic            use_imm, // 1 selects imm as operand b
    input  core_pkg::word_t op_a,
    input  core_pkg::word_t op_b,
    input  core_pkg::word_t imm,
    output core_pkg::word_t result
);

    core_pkg::word_t b;
    logic [4:0]      shamt;
    logic            alt;      // funct7 marks sub / sra
    logic            do_sub;

    assign b      = use_imm ? imm : op_b;
    assign shamt  = b[4:0]; // only low five bits shift
    assign alt    = (funct7 == rv_isa_pkg::funct7_alt);
    assign do_sub = alt && !use_imm; // addi has no subtract form

    always_comb begin
        case (funct3)
            rv_isa_pkg::f3_add_sub: result = do_sub ? op_a - b : op_a + b;
            rv_isa_pkg::f3_sll:     result = op_a << shamt;
            rv_isa_pkg::f3_slt: begin
                result = {31'b0, $signed(op_a) < $signed(b)};
            end
            rv_isa_pkg::f3_sltu:    result = {31'b0, op_a < b};
            rv_isa_pkg::f3_xor:     result = op_a ^ b;
            rv_isa_pkg::f3_srl_sra: begin
                // srai keeps funct7 in imm[11:5], so alt applies to both forms
                if (alt) result = core_pkg::word_t'($signed(op_a) >>> shamt);
                else     result = op_a >> shamt;
            end
            rv_isa_pkg::f3_or:      result = op_a | b;
            default:                result = op_a & b; // f3_and
        endcase
    end

endmodule

//--- design/branch_unit.sv
module branch_unit (
    input  logic [2:0]      funct3,
    input  core_pkg::word_t op_a,  // rs1
    input  core_pkg::word_t op_b,  // rs2
    output logic            taken
);

    logic eq;
    logic lt;   // signed
    logic ltu;  // unsigned

    assign eq  = (op_a == op_b);
    assign lt  = $signed(op_a) < $signed(op_b);
    assign ltu = op_a < op_b;

    always_comb begin
        case (funct3)
            rv_isa_pkg::f3_beq:  taken = eq;
            rv_isa_pkg::f3_bne:  taken = !eq;
            rv_isa_pkg::f3_blt:  taken = lt;
            rv_isa_pkg::f3_bge:  taken = !lt;
            rv_isa_pkg::f3_bltu: taken = ltu;
            rv_isa_pkg::f3_bgeu: taken = !ltu;
            default:             taken = 1'b0; // 010 / 011 not defined
        endcase
    end

endmodule

//--- design/core.sv
module core (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               clk_enable,  // low freezes all state
    output logic               cycle_end,   // high in init and writeback

    // instruction memory, data one edge after imem_r_en
    output logic               imem_r_en,
    output core_pkg::word_t    imem_r_addr,
    input  core_pkg::word_t    imem_r_data,

    // data memory
    output logic               dmem_r_en,
    output core_pkg::word_t    dmem_r_addr,
    input  core_pkg::word_t    dmem_r_data,
    output logic               dmem_w_en,
    output core_pkg::word_t    dmem_w_addr,
    output core_pkg::word_t    dmem_w_data,

    // debug
    output logic [3:0]         dbg_state,
    output core_pkg::word_t    dbg_pc,
    input  core_pkg::reg_idx_t dbg_reg_sel,
    output core_pkg::word_t    dbg_reg_data
);

    core_pkg::core_state_t state;
    core_pkg::word_t       pc;
    core_pkg::word_t       instr;     // instruction register

    // instruction fields
    rv_isa_pkg::opcode_t   opcode;
    core_pkg::reg_idx_t    rd;
    logic [2:0]            funct3;
    logic [6:0]            funct7;

    core_pkg::word_t       imm;
    core_pkg::word_t       alu_result;
    logic                  br_taken;

    core_pkg::word_t       pc_plus4;
    core_pkg::word_t       pc_imm;    // branch / jal target, auipc value
    core_pkg::word_t       base_imm;  // rs1 + imm, load/store address and jalr target
    core_pkg::word_t       next_pc;
    core_pkg::word_t       wb_data;
    logic                  wb_en;     // instruction writes rd

    // register write is registered so it holds through a stall
    logic                  reg_w_en;
    core_pkg::reg_idx_t    reg_w_sel;
    core_pkg::word_t       reg_w_data;

    regfile_if rf_bus ();

    assign opcode = rv_isa_pkg::opcode_t'(instr[6:0]);
    assign rd     = instr[rv_isa_pkg::rd_lsb +: 5];
    assign funct3 = instr[rv_isa_pkg::funct3_lsb +: 3];
    assign funct7 = instr[rv_isa_pkg::funct7_lsb +: 7];

    assign rf_bus.r_sel_1 = instr[rv_isa_pkg::rs1_lsb +: 5];
    assign rf_bus.r_sel_2 = instr[rv_isa_pkg::rs2_lsb +: 5];
    assign rf_bus.w_en    = reg_w_en;
    assign rf_bus.w_sel   = reg_w_sel;
    assign rf_bus.w_data  = reg_w_data;

    assign imem_r_addr = pc; // fetch always from pc
    assign cycle_end   = (state == core_pkg::writeback) || (state == core_pkg::init);
    assign dbg_state   = state;
    assign dbg_pc      = pc;

    regfile u_regfile (
        .clk      (clk),
        .rst_n    (rst_n),
        .dbg_sel  (dbg_reg_sel),
        .bus      (rf_bus.rf),
        .dbg_data (dbg_reg_data)
    );

    imm_decoder u_imm_decoder (
        .instr (instr),
        .imm   (imm)
    );

    alu u_alu (
        .funct3  (funct3),
        .funct7  (funct7),
        .use_imm (~instr[5]), // bit 5 clear for op_alui
        .op_a    (rf_bus.r_data_1),
        .op_b    (rf_bus.r_data_2),
        .imm     (imm),
        .result  (alu_result)
    );

    branch_unit u_branch_unit (
        .funct3 (funct3),
        .op_a   (rf_bus.r_data_1),
        .op_b   (rf_bus.r_data_2),
        .taken  (br_taken)
    );

    assign pc_plus4 = pc + core_pkg::word_t'(4);
    assign pc_imm   = pc + imm;
    assign base_imm = rf_bus.r_data_1 + imm;

    // value for rd, sampled in writeback
    always_comb begin
        wb_data = alu_result;
        wb_en   = 1'b1;
        case (opcode)
            rv_isa_pkg::op_alu, rv_isa_pkg::op_alui: wb_data = alu_result;
            rv_isa_pkg::op_load:                     wb_data = dmem_r_data;
            rv_isa_pkg::op_jal, rv_isa_pkg::op_jalr: wb_data = pc_plus4; // link
            rv_isa_pkg::op_lui:                      wb_data = imm;
            rv_isa_pkg::op_auipc:                    wb_data = pc_imm;
            default:                                 wb_en   = 1'b0; // store, branch
        endcase
    end

    // pc for the next fetch
    always_comb begin
        next_pc = pc_plus4;
        case (opcode)
            rv_isa_pkg::op_jal:    next_pc = pc_imm;
            rv_isa_pkg::op_jalr:   next_pc = {base_imm[31:1], 1'b0}; // clear bit 0
            rv_isa_pkg::op_branch: if (br_taken) next_pc = pc_imm;
            default:               next_pc = pc_plus4;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= core_pkg::init;
            pc        <= core_pkg::reset_pc;
            imem_r_en <= 1'b0;
            dmem_r_en <= 1'b0;
            dmem_w_en <= 1'b0;
            reg_w_en  <= 1'b0;
        end else if (clk_enable) begin
            case (state)
                core_pkg::init: begin
                    pc        <= core_pkg::reset_pc;
                    imem_r_en <= 1'b1; // request first instruction
                    state     <= core_pkg::fetch;
                end
                core_pkg::fetch: begin
                    imem_r_en <= 1'b0; // memory has sampled the request
                    reg_w_en  <= 1'b0; // previous rd write lands on this edge
                    state     <= core_pkg::decode;
                end
                core_pkg::decode: begin
                    instr <= imem_r_data;
                    state <= core_pkg::execute;
                end
                core_pkg::execute: begin
                    state <= core_pkg::memory;
                    case (opcode)
                        rv_isa_pkg::op_load: begin
                            dmem_r_en   <= 1'b1;
                            dmem_r_addr <= base_imm;
                        end
                        rv_isa_pkg::op_store: begin
                            dmem_w_en   <= 1'b1;
                            dmem_w_addr <= base_imm;
                            dmem_w_data <= rf_bus.r_data_2;
                        end
                        rv_isa_pkg::op_alu, rv_isa_pkg::op_alui, rv_isa_pkg::op_branch,
                        rv_isa_pkg::op_jal, rv_isa_pkg::op_jalr, rv_isa_pkg::op_lui,
                        rv_isa_pkg::op_auipc: begin
                            // nothing to start, results are read in writeback
                        end
                        rv_isa_pkg::op_system: state <= core_pkg::halt;
                        default:               state <= core_pkg::error;
                    endcase
                end
                core_pkg::memory: begin
                    // access is sampled on this edge, load data valid in writeback
                    dmem_r_en <= 1'b0;
                    dmem_w_en <= 1'b0;
                    state     <= core_pkg::writeback;
                end
                core_pkg::writeback: begin
                    reg_w_en   <= wb_en;
                    reg_w_sel  <= rd;
                    reg_w_data <= wb_data;
                    pc         <= next_pc;
                    imem_r_en  <= 1'b1; // fetch next
                    state      <= core_pkg::fetch;
                end
                core_pkg::halt, core_pkg::error: begin
                    // stays here until reset, all enables already low
                end
                default: state <= core_pkg::error; // unused codes
            endcase
        end
    end

endmodule

//--- verification/tb_clk_gen.sv
module tb_clk_gen (
    input  logic restart, // rising edge starts another reset
    output logic clk,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 1ps;

    initial clk = 1'b0;
    always #5 clk = ~clk; // 10 ns period

    // reset low for 4 rising edges, released on a falling edge
    initial begin
        rst_n = 1'b0;
        forever begin
            repeat (4) @(negedge clk);
            rst_n = 1'b1;
            @(posedge restart);
            rst_n = 1'b0;
        end
    end
endmodule

//--- verification/tb_core.sv
module tb_core;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int prog_len = 60; // ecall sits at index prog_len

    logic clk, rst_n;
    logic restart = 1'b0;
    logic clk_enable = 1'b1;
    logic cycle_end, imem_r_en, dmem_r_en, dmem_w_en;
    core_pkg::word_t imem_r_addr, dmem_r_addr, dmem_w_addr, dmem_w_data;
    core_pkg::word_t imem_r_data = '0;
    core_pkg::word_t dmem_r_data = '0;
    core_pkg::word_t dbg_pc, dbg_reg_data;
    core_pkg::reg_idx_t dbg_reg_sel = '0;
    logic [3:0] dbg_state;

    // program kept as fields and encoded into imem
    rv_isa_pkg::opcode_t p_op [64];
    core_pkg::reg_idx_t p_rd [64], p_rs1 [64], p_rs2 [64];
    logic [2:0] p_f3 [64];
    logic p_alt [64];
    core_pkg::word_t p_imm [64];

    core_pkg::word_t imem [64], dmem [256];  // memories seen by the DUT
    core_pkg::word_t ref_x [32], ref_mem [256]; // reference model state
    core_pkg::word_t exp_pc [$], exp_st_addr [$], exp_st_data [$];
    int errors = 0;
    int retired = 0;
    logic timed_out = 1'b0;
    core_pkg::core_state_t prev_state = core_pkg::init;

    tb_clk_gen u_clk_gen (.restart(restart), .clk(clk), .rst_n(rst_n));

    core u_core (
        .clk(clk), .rst_n(rst_n), .clk_enable(clk_enable), .cycle_end(cycle_end),
        .imem_r_en(imem_r_en), .imem_r_addr(imem_r_addr), .imem_r_data(imem_r_data),
        .dmem_r_en(dmem_r_en), .dmem_r_addr(dmem_r_addr), .dmem_r_data(dmem_r_data),
        .dmem_w_en(dmem_w_en), .dmem_w_addr(dmem_w_addr), .dmem_w_data(dmem_w_data),
        .dbg_state(dbg_state), .dbg_pc(dbg_pc), .dbg_reg_sel(dbg_reg_sel),
        .dbg_reg_data(dbg_reg_data)
    );

    // both memories answer one cycle after the read enable and write on the edge
    always @(posedge clk) begin
        if (imem_r_en) imem_r_data <= imem[imem_r_addr[7:2]];
        if (dmem_r_en) dmem_r_data <= dmem[dmem_r_addr[9:2]];
        if (dmem_w_en) dmem[dmem_w_addr[9:2]] <= dmem_w_data;
    end

    always @(negedge clk) clk_enable <= ($urandom_range(4) != 0); // ~1 in 5 stalled

    task automatic check_word(input string name, input core_pkg::word_t act,
                              input core_pkg::word_t exp);
        if (act !== exp) begin
            errors++;
            $display("FAIL t=%0t %s actual=%08h expected=%08h", $time, name, act, exp);
        end
    endtask

    task automatic check_state(input core_pkg::core_state_t act,
                               input core_pkg::core_state_t exp);
        if (act !== exp) begin
            errors++;
            $display("FAIL t=%0t dbg_state actual=%s expected=%s", $time, act.name(), exp.name());
        end
    endtask

    // retire and store monitor checks once on entry into each state
    always @(negedge clk) begin
        core_pkg::core_state_t cur;
        cur = core_pkg::core_state_t'(dbg_state);
        if (cur == core_pkg::writeback && prev_state != core_pkg::writeback) begin
            retired++;
            if (!cycle_end) begin
                errors++;
                $display("cycle_end low in writeback at t=%0t", $time);
            end
            if (exp_pc.size() == 0) begin
                errors++;
                $display("core retired more instructions than the model at t=%0t", $time);
            end else check_word("dbg_pc", dbg_pc, exp_pc.pop_front());
        end
        if (cur == core_pkg::memory && prev_state != core_pkg::memory && dmem_w_en) begin
            if (exp_st_addr.size() == 0) begin
                errors++;
                $display("unexpected data memory write at t=%0t", $time);
            end else begin
                check_word("dmem_w_addr", dmem_w_addr, exp_st_addr.pop_front());
                check_word("dmem_w_data", dmem_w_data, exp_st_data.pop_front());
            end
        end
        prev_state = cur;
    end

    function automatic core_pkg::word_t fill_word(int a);
        return core_pkg::word_t'(a) * 32'h9e3779b9 ^ 32'hef14f3dc; // whole address mixed in
    endfunction

    function automatic core_pkg::reg_idx_t rnd_reg();
        return core_pkg::reg_idx_t'($urandom_range(31));
    endfunction

    task automatic set_slot(input int i, input rv_isa_pkg::opcode_t op,
                            input core_pkg::reg_idx_t rd, input core_pkg::reg_idx_t rs1,
                            input core_pkg::reg_idx_t rs2, input logic [2:0] f3,
                            input logic alt, input core_pkg::word_t imm);
        p_op[i] = op;
        p_rd[i] = rd;
        p_rs1[i] = rs1;
        p_rs2[i] = rs2;
        p_f3[i] = f3;
        p_alt[i] = alt;
        p_imm[i] = imm;
    endtask

    // standard rv32i field layouts
    function automatic core_pkg::word_t encode(int i);
        core_pkg::word_t m;
        logic [6:0] f7;
        logic [6:0] op;
        m = p_imm[i];
        f7 = p_alt[i] ? rv_isa_pkg::funct7_alt : 7'd0;
        op = p_op[i];
        case (p_op[i])
            rv_isa_pkg::op_alu: return {f7, p_rs2[i], p_rs1[i], p_f3[i], p_rd[i], op};
            rv_isa_pkg::op_alui, rv_isa_pkg::op_load, rv_isa_pkg::op_jalr:
                return {m[11:0], p_rs1[i], p_f3[i], p_rd[i], op};
            rv_isa_pkg::op_store: return {m[11:5], p_rs2[i], p_rs1[i], p_f3[i], m[4:0], op};
            rv_isa_pkg::op_branch:
                return {m[12], m[10:5], p_rs2[i], p_rs1[i], p_f3[i], m[4:1], m[11], op};
            rv_isa_pkg::op_lui, rv_isa_pkg::op_auipc: return {m[31:12], p_rd[i], op};
            rv_isa_pkg::op_jal: return {m[20], m[10:1], m[11], m[19:12], p_rd[i], op};
            default: return 32'h0000_0073; // ecall
        endcase
    endfunction

    task automatic gen_program();
        int i, k, kind;
        logic [2:0] f3;
        logic alt;
        core_pkg::reg_idx_t rb;
        logic landing [64]; // slot reached by a jump or a taken branch
        for (int j = 0; j < 64; j++) begin
            set_slot(j, rv_isa_pkg::op_system, 0, 0, 0, 0, 0, '0);
            landing[j] = 1'b0;
        end
        i = 0;
        while (i < prog_len) begin
            kind = $urandom_range(9);
            // jalr pair needs two slots and no jump may skip its addi
            if (kind == 9 && (i > prog_len - 2 || landing[i + 1])) kind = 0;
            k = $urandom_range(4, 1); // forward distance in words
            f3 = 3'($urandom_range(7));
            alt = (f3 == 3'd0 || f3 == 3'd5) && ($urandom_range(1) == 1);
            case (kind)
                0, 1: set_slot(i, rv_isa_pkg::op_alu, rnd_reg(), rnd_reg(), rnd_reg(), f3, alt, '0);
                2, 3: begin
                    if (f3 == 3'd1 || f3 == 3'd5) begin
                        alt = alt && f3 == 3'd5;
                        set_slot(i, rv_isa_pkg::op_alui, rnd_reg(), rnd_reg(), 0, f3, alt,
                                 {20'd0, alt ? 7'h20 : 7'h00, 5'($urandom_range(31))});
                    end else begin
                        set_slot(i, rv_isa_pkg::op_alui, rnd_reg(), rnd_reg(), 0, f3, 1'b0,
                                 core_pkg::word_t'($signed(12'($urandom()))));
                    end
                end
                4: set_slot(i, ($urandom_range(1) == 1) ? rv_isa_pkg::op_lui : rv_isa_pkg::op_auipc,
                            rnd_reg(), 0, 0, 0, 0, {20'($urandom()), 12'd0});
                5: set_slot(i, rv_isa_pkg::op_load, rnd_reg(), 0, 0, 3'b010, 0,
                            core_pkg::word_t'($urandom_range(255) * 4));
                6: set_slot(i, rv_isa_pkg::op_store, 0, 0, rnd_reg(), 3'b010, 0,
                            core_pkg::word_t'($urandom_range(255) * 4));
                7, 8: begin
                    if (k > prog_len - i) k = prog_len - i;
                    landing[i + k] = 1'b1;
                    if (kind == 8) set_slot(i, rv_isa_pkg::op_jal, rnd_reg(), 0, 0, 0, 0,
                                            core_pkg::word_t'(k * 4));
                    else set_slot(i, rv_isa_pkg::op_branch, 0, rnd_reg(), rnd_reg(),
                                  (f3[2:1] == 2'b01) ? 3'b000 : f3, 0, core_pkg::word_t'(k * 4));
                end
                default: begin
                    // addi sets the base and jalr adds an odd offset whose bit 0 is dropped
                    if (k > prog_len - i - 1) k = prog_len - i - 1;
                    landing[i + 1 + k] = 1'b1;
                    rb = core_pkg::reg_idx_t'($urandom_range(31, 1));
                    set_slot(i, rv_isa_pkg::op_alui, rb, 0, 0, rv_isa_pkg::f3_add_sub, 0,
                             core_pkg::word_t'((i + 1 + k) * 4));
                    set_slot(i + 1, rv_isa_pkg::op_jalr, rnd_reg(), rb, 0, 0, 0, 32'd1);
                    i++;
                end
            endcase
            i++;
        end
    endtask

    function automatic core_pkg::word_t ref_alu(logic [2:0] f3, logic sub, logic sra,
                                                core_pkg::word_t a, core_pkg::word_t b);
        case (f3)
            3'd0: return sub ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return {31'd0, $signed(a) < $signed(b)};
            3'd3: return {31'd0, a < b};
            3'd4: return a ^ b;
            3'd5: return sra ? core_pkg::word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic ref_taken(logic [2:0] f3, core_pkg::word_t a, core_pkg::word_t b);
        case (f3)
            3'd0: return a == b;
            3'd1: return a != b;
            3'd4: return $signed(a) < $signed(b);
            3'd5: return $signed(a) >= $signed(b);
            3'd6: return a < b;
            3'd7: return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    task automatic write_ref(input core_pkg::reg_idx_t rd, input core_pkg::word_t v);
        if (rd != 0) ref_x[rd] = v; // x0 stays zero
    endtask

    task automatic run_model();
        core_pkg::word_t pc, a, b, ad, tgt, imm;
        int idx, steps;
        for (int r = 0; r < 32; r++) ref_x[r] = '0;
        for (int j = 0; j < 256; j++) ref_mem[j] = fill_word(j);
        pc = core_pkg::reset_pc;
        steps = 0;
        while (steps < 1000) begin
            idx = int'(pc >> 2);
            if (idx > prog_len) begin
                errors++;
                $display("reference model left the program at pc %08h", pc);
                break;
            end
            if (p_op[idx] == rv_isa_pkg::op_system) break;
            exp_pc.push_back(pc);
            a = ref_x[p_rs1[idx]];
            b = ref_x[p_rs2[idx]];
            imm = p_imm[idx];
            ad = a + imm;
            tgt = pc + 4;
            case (p_op[idx])
                rv_isa_pkg::op_alu: begin
                    write_ref(p_rd[idx], ref_alu(p_f3[idx], p_alt[idx], p_alt[idx], a, b));
                end
                rv_isa_pkg::op_alui: begin
                    write_ref(p_rd[idx], ref_alu(p_f3[idx], 1'b0, p_alt[idx], a, imm));
                end
                rv_isa_pkg::op_load: write_ref(p_rd[idx], ref_mem[ad[9:2]]);
                rv_isa_pkg::op_store: begin
                    ref_mem[ad[9:2]] = b;
                    exp_st_addr.push_back(ad);
                    exp_st_data.push_back(b);
                end
                rv_isa_pkg::op_branch: if (ref_taken(p_f3[idx], a, b)) tgt = pc + imm;
                rv_isa_pkg::op_jal: begin
                    write_ref(p_rd[idx], pc + 4);
                    tgt = pc + imm;
                end
                rv_isa_pkg::op_jalr: begin
                    tgt = ad & ~32'd1; // target taken before rd is written
                    write_ref(p_rd[idx], pc + 4);
                end
                rv_isa_pkg::op_lui: write_ref(p_rd[idx], imm);
                default: write_ref(p_rd[idx], pc + imm); // auipc
            endcase
            pc = tgt;
            steps++;
        end
    endtask

    task automatic wait_state(input core_pkg::core_state_t want, input string what);
        int n;
        n = 0;
        while (core_pkg::core_state_t'(dbg_state) != want && n < 2000) begin
            @(negedge clk);
            n++;
        end
        if (core_pkg::core_state_t'(dbg_state) != want) begin
            errors++;
            timed_out = 1'b1;
            $display("core never reached %s within 2000 cycles", what);
        end
    endtask

    task automatic wait_rst(input logic level, input string what);
        int n;
        n = 0;
        while (rst_n !== level && n < 2000) begin
            @(negedge clk);
            n++;
        end
        if (rst_n !== level) begin
            errors++;
            timed_out = 1'b1;
            $display("reset never reached %s within 2000 cycles", what);
        end
    endtask

    task automatic check_idle();
        if (imem_r_en || dmem_r_en || dmem_w_en) begin
            errors++;
            $display("memory enable high in a stopped state at t=%0t", $time);
        end
    endtask

    initial begin
        void'($urandom(32'hef14f3dc));
        gen_program();
        run_model();
        for (int j = 0; j < 64; j++) imem[j] = encode(j);
        for (int j = 0; j < 256; j++) dmem[j] = fill_word(j);
        @(negedge clk); // first rising edge has applied reset
        check_state(core_pkg::core_state_t'(dbg_state), core_pkg::init);
        check_idle();
        if (!cycle_end) begin
            errors++;
            $display("cycle_end low after reset at t=%0t", $time);
        end
        wait_rst(1'b1, "release");
        wait_state(core_pkg::halt, "halt");
        if (!timed_out) begin
            for (int c = 0; c < 20; c++) begin
                @(negedge clk);
                check_state(core_pkg::core_state_t'(dbg_state), core_pkg::halt);
                check_idle();
            end
            if (exp_pc.size() != 0 || exp_st_addr.size() != 0) begin
                errors++;
                $display("core halted before retiring every instruction of the model");
            end
            for (int r = 0; r < 32; r++) begin
                @(negedge clk);
                dbg_reg_sel = core_pkg::reg_idx_t'(r);
                @(posedge clk);
                check_word($sformatf("x%0d", r), dbg_reg_data, ref_x[r]);
            end
            for (int j = 0; j < 256; j++) begin
                check_word($sformatf("dmem[%0d]", j), dmem[j], ref_mem[j]);
            end
            // second run starts from an illegal opcode with rd = x31 at address 0
            @(negedge clk);
            imem[0] = 32'h0000_0f8b;
            restart = 1'b1;
            wait_rst(1'b0, "assertion");
            wait_rst(1'b1, "release");
            restart = 1'b0;
            wait_state(core_pkg::error, "error");
        end
        if (!timed_out) begin
            @(negedge clk);
            check_idle();
            check_word("dbg_pc", dbg_pc, core_pkg::reset_pc);
            for (int r = 0; r < 32; r++) begin
                @(negedge clk);
                dbg_reg_sel = core_pkg::reg_idx_t'(r);
                @(posedge clk);
                check_word($sformatf("x%0d", r), dbg_reg_data, '0);
            end
        end
        $display("errors: %0d, instructions retired: %0d", errors, retired);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end
endmodule

//--- compile.f
design/rv_isa_pkg.sv
design/core_pkg.sv
design/regfile_if.sv
design/regfile.sv
design/imm_decoder.sv
design/alu.sv
design/branch_unit.sv
design/core.sv
verification/tb_clk_gen.sv
verification/tb_core.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --timescale 1ns/1ps -j 0
TOP       = tb_core
FILELIST  = compile.f
PASS_MSG  = Test completed successfully

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir
